//--- fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// Virtual PC width
`define FE_VADDR_WIDTH 16

// Instruction word width
`define FE_INSTR_WIDTH 32

// Instruction memory geometry, in 32-bit words
`define FE_IMEM_WORDS 64
`define FE_IMEM_ADDR_WIDTH 6

// Sequential fetch increment in bytes
`define FE_PC_STEP 4

`endif

//--- fe_ctrl.sv
`timescale 1ns/1ps
`include "fe_consts.svh"

module fe_ctrl
  (input  logic                               clk_i
   , input  logic                             reset_i
   , input  fe_pkg::fe_cmd_s                  fe_cmd_i
   , input  logic                             fe_cmd_v_i
   , output logic                             fe_cmd_yumi_o
   , input  logic                             fetch_done_i
   , input  logic                             exception_done_i
   , input  logic                             fetch_fail_i
   , input  logic [`FE_VADDR_WIDTH-1:0]       if1_pc_i
   , input  logic                             if1_v_i
   , input  logic [`FE_VADDR_WIDTH-1:0]       if2_pc_i
   , input  logic                             if2_v_i
   , input  logic                             fe_queue_ready_i
   , output fe_pkg::fe_redirect_s             redirect_o
   , output logic                             fetch_en_o
   // Bit 0 flushes IF1, bit 1 flushes IF2
   , output logic [1:0]                       flush_o
   , output logic                             fill_v_o
   , output logic [`FE_IMEM_ADDR_WIDTH-1:0]   fill_addr_o
   , output logic [`FE_INSTR_WIDTH-1:0]       fill_data_o
   );

  fe_pkg::fe_state_e state_r, state_n;
  logic [`FE_VADDR_WIDTH-1:0] resume_r, resume_n;
  logic cmd_v, redirect_cmd, fill_cmd, wait_cmd;
  logic resume_go, if2_pending, resume_en, kill;

  // Every command is taken in the cycle it shows up
  assign fe_cmd_yumi_o = fe_cmd_v_i & ~reset_i;
  assign cmd_v         = fe_cmd_yumi_o;

  assign redirect_cmd = cmd_v & (fe_cmd_i.opcode == fe_pkg::e_op_pc_redirect);
  assign fill_cmd     = cmd_v & (fe_cmd_i.opcode == fe_pkg::e_op_imem_fill);
  assign wait_cmd     = cmd_v & (fe_cmd_i.opcode == fe_pkg::e_op_wait);

  // A pending command delays the replay by a cycle
  assign resume_go   = (state_r == fe_pkg::e_stall) & fe_queue_ready_i & ~cmd_v;
  assign if2_pending = if2_v_i & ~fetch_done_i & ~exception_done_i;

  always_comb
  begin
    case (state_r)
      fe_pkg::e_wait:
        state_n = redirect_cmd ? fe_pkg::e_run : fe_pkg::e_wait;
      fe_pkg::e_run:
        if (redirect_cmd)
          state_n = fe_pkg::e_run;
        else if (wait_cmd || exception_done_i)
          state_n = fe_pkg::e_wait;
        else if (fill_cmd || fetch_fail_i)
          state_n = fe_pkg::e_stall;
        else
          state_n = fe_pkg::e_run;
      fe_pkg::e_stall:
        if (redirect_cmd || resume_go)
          state_n = fe_pkg::e_run;
        else if (wait_cmd)
          state_n = fe_pkg::e_wait;
        else
          state_n = fe_pkg::e_stall;
      default:
        state_n = fe_pkg::e_wait;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= fe_pkg::e_wait;
    else
      state_r <= state_n;
  end

  // Oldest PC not yet handed to the queue
  assign resume_n  = redirect_cmd ? fe_cmd_i.vaddr : (if2_pending ? if2_pc_i : if1_pc_i);
  assign resume_en = redirect_cmd
                   | ((state_r == fe_pkg::e_run) & (fill_cmd | fetch_fail_i)
                      & (if2_pending | if1_v_i));

  always_ff @(posedge clk_i)
  begin
    if (resume_en)
      resume_r <= resume_n;
  end

  assign redirect_o = '{v: redirect_cmd | resume_go,
                        pc: redirect_cmd ? fe_cmd_i.vaddr : resume_r};
  assign fetch_en_o = (state_n == fe_pkg::e_run);

  // IF1 is refilled by the new fetch whenever fetching continues
  assign kill    = redirect_cmd | fill_cmd | wait_cmd | fetch_fail_i | exception_done_i;
  assign flush_o = {kill, kill & ~fetch_en_o};

  assign fill_v_o    = fill_cmd;
  assign fill_addr_o = fe_cmd_i.vaddr[`FE_IMEM_ADDR_WIDTH+1:2];
  assign fill_data_o = fe_cmd_i.instr;

  // Nothing is fetched or in flight unless the FSM is running
  a_idle_stages_empty : assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r != fe_pkg::e_run) |-> (!if1_v_i && !if2_v_i));

endmodule

//--- fe_imem.sv
`timescale 1ns/1ps
`include "fe_consts.svh"

module fe_imem
  (input  logic                               clk_i
   , input  logic                             reset_i
   , input  logic [`FE_VADDR_WIDTH-1:0]       rd_pc_i
   , input  logic                             fill_v_i
   , input  logic [`FE_IMEM_ADDR_WIDTH-1:0]   fill_addr_i
   , input  logic [`FE_INSTR_WIDTH-1:0]       fill_data_i
   , output logic                             misaligned_o
   , output logic                             out_of_range_o
   , output logic [`FE_INSTR_WIDTH-1:0]       instr_o
   );

  logic [`FE_INSTR_WIDTH-1:0] mem [`FE_IMEM_WORDS];

  logic [`FE_VADDR_WIDTH-3:0]    word_idx;
  logic [`FE_IMEM_ADDR_WIDTH-1:0] rd_addr;
  logic [`FE_INSTR_WIDTH-1:0]    rd_data_r;
  logic                          rd_v_r;

  assign word_idx       = rd_pc_i[`FE_VADDR_WIDTH-1:2];
  assign rd_addr        = word_idx[`FE_IMEM_ADDR_WIDTH-1:0];
  assign misaligned_o   = |rd_pc_i[1:0];
  assign out_of_range_o = (word_idx >= `FE_IMEM_WORDS);

  always_ff @(posedge clk_i)
  begin
    if (fill_v_i)
      mem[fill_addr_i] <= fill_data_i;
  end

  // Read first, a fill to the same word shows up on the next read
  always_ff @(posedge clk_i)
  begin
    if (!out_of_range_o)
      rd_data_r <= mem[rd_addr];
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rd_v_r <= 1'b0;
    else
      rd_v_r <= ~out_of_range_o;
  end

  // Skipped reads return zero
  assign instr_o = rd_v_r ? rd_data_r : '0;

endmodule

//--- fe_msg_former.sv
`timescale 1ns/1ps
`include "fe_consts.svh"

module fe_msg_former
  (input  logic                           if2_v_i
   , input  fe_pkg::fe_if2_s              if2_i
   , input  logic [`FE_INSTR_WIDTH-1:0]   instr_i
   , input  logic                         fe_queue_ready_i
   , output fe_pkg::fe_queue_s            fe_queue_o
   , output logic                         fe_queue_v_o
   , output logic                         fetch_done_o
   , output logic                         exception_done_o
   , output logic                         fetch_fail_o
   );

  logic is_exc;

  assign is_exc = if2_i.misaligned | if2_i.out_of_range;

  always_comb
  begin
    fe_queue_o    = '0;
    fe_queue_o.pc = if2_i.pc;
    if (is_exc)
    begin
      fe_queue_o.msg_type = fe_pkg::e_fe_exception;
      // Misalignment wins when both checks trip
      fe_queue_o.exc_code = if2_i.misaligned ? fe_pkg::e_instr_misaligned
                                             : fe_pkg::e_instr_access_fault;
    end
    else
    begin
      fe_queue_o.msg_type = fe_pkg::e_fe_fetch;
      fe_queue_o.instr    = instr_i;
    end
  end

  assign fe_queue_v_o     = if2_v_i & fe_queue_ready_i;
  assign fetch_done_o     = fe_queue_v_o & ~is_exc;
  assign exception_done_o = fe_queue_v_o & is_exc;
  assign fetch_fail_o     = if2_v_i & ~fe_queue_ready_i;

endmodule

//--- fe_pc_gen.sv
`timescale 1ns/1ps
`include "fe_consts.svh"

module fe_pc_gen
  (input  logic                           clk_i
   , input  logic                         reset_i
   , input  fe_pkg::fe_redirect_s         redirect_i
   , input  logic                         fetch_en_i
   , output logic [`FE_VADDR_WIDTH-1:0]   next_pc_o
   );

  localparam logic [`FE_VADDR_WIDTH-1:0] pc_step_lp = `FE_PC_STEP;

  // Last PC issued into IF1
  logic [`FE_VADDR_WIDTH-1:0] pc_r;

  always_comb
  begin
    if (redirect_i.v)
      next_pc_o = redirect_i.pc;
    else
      next_pc_o = pc_r + pc_step_lp;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      pc_r <= '0;
    else if (fetch_en_i)
      pc_r <= next_pc_o;
  end

endmodule

//--- fe_pkg.sv
`include "fe_consts.svh"

package fe_pkg;

  // Commands from the back end
  typedef enum logic [1:0]
  {
    e_op_pc_redirect = 2'd0,
    e_op_imem_fill   = 2'd1,
    e_op_wait        = 2'd2
  } fe_cmd_opcode_e;

  // vaddr is the redirect target, or the byte address of the fill word
  typedef struct packed
  {
    fe_cmd_opcode_e              opcode;
    logic [`FE_VADDR_WIDTH-1:0]  vaddr;
    logic [`FE_INSTR_WIDTH-1:0]  instr;
  } fe_cmd_s;

  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  typedef enum logic
  {
    e_instr_misaligned   = 1'b0,
    e_instr_access_fault = 1'b1
  } fe_exc_code_e;

  typedef struct packed
  {
    fe_msg_type_e                msg_type;
    fe_exc_code_e                exc_code;
    logic [`FE_VADDR_WIDTH-1:0]  pc;
    logic [`FE_INSTR_WIDTH-1:0]  instr;
  } fe_queue_s;

  typedef enum logic [1:0]
  {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

  typedef struct packed
  {
    logic [`FE_VADDR_WIDTH-1:0]  pc;
  } fe_if1_s;

  typedef struct packed
  {
    logic [`FE_VADDR_WIDTH-1:0]  pc;
    logic                        misaligned;
    logic                        out_of_range;
  } fe_if2_s;

  typedef struct packed
  {
    logic                        v;
    logic [`FE_VADDR_WIDTH-1:0]  pc;
  } fe_redirect_s;

endpackage

//--- fe_stage_reg.sv
`timescale 1ns/1ps

module fe_stage_reg
  #(parameter type payload_t = logic)
  (input  logic        clk_i
   , input  logic      reset_i
   , input  logic      v_i
   , input  payload_t  data_i
   , input  logic      flush_i
   , output logic      v_o
   , output payload_t  data_o
   );

  logic     v_r;
  payload_t data_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      v_r <= 1'b0;
    else
      v_r <= v_i & ~flush_i;
  end

  // Payload only moves with a valid item
  always_ff @(posedge clk_i)
  begin
    if (v_i)
      data_r <= data_i;
  end

  assign v_o    = v_r;
  assign data_o = data_r;

  a_data_known : assert property (@(posedge clk_i) disable iff (reset_i)
    v_o |-> !$isunknown(data_o));

endmodule

//--- fe_top.f
+incdir+.
fe_pkg.sv
fe_stage_reg.sv
fe_pc_gen.sv
fe_imem.sv
fe_msg_former.sv
fe_ctrl.sv
fe_top.sv
tb_fe_top.sv

//--- fe_top.sv
`timescale 1ns/1ps
`include "fe_consts.svh"

module fe_top
  (input  logic                 clk_i
   , input  logic               reset_i
   , input  fe_pkg::fe_cmd_s    fe_cmd_i
   , input  logic               fe_cmd_v_i
   , output logic               fe_cmd_yumi_o
   , output fe_pkg::fe_queue_s  fe_queue_o
   , output logic               fe_queue_v_o
   , input  logic               fe_queue_ready_i
   );

  fe_pkg::fe_redirect_s redirect;
  logic fetch_en;
  logic [1:0] flush;
  logic fill_v;
  logic [`FE_IMEM_ADDR_WIDTH-1:0] fill_addr;
  logic [`FE_INSTR_WIDTH-1:0] fill_data;
  logic [`FE_VADDR_WIDTH-1:0] next_pc;

  fe_pkg::fe_if1_s if1_n, if1_q;
  fe_pkg::fe_if2_s if2_n, if2_q;
  logic if1_v, if2_v;

  logic imem_misaligned, imem_out_of_range;
  logic [`FE_INSTR_WIDTH-1:0] imem_instr;
  logic fetch_done, exception_done, fetch_fail;

  fe_ctrl ctrl
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.fe_cmd_i(fe_cmd_i)
     ,.fe_cmd_v_i(fe_cmd_v_i)
     ,.fe_cmd_yumi_o(fe_cmd_yumi_o)
     ,.fetch_done_i(fetch_done)
     ,.exception_done_i(exception_done)
     ,.fetch_fail_i(fetch_fail)
     ,.if1_pc_i(if1_q.pc)
     ,.if1_v_i(if1_v)
     ,.if2_pc_i(if2_q.pc)
     ,.if2_v_i(if2_v)
     ,.fe_queue_ready_i(fe_queue_ready_i)
     ,.redirect_o(redirect)
     ,.fetch_en_o(fetch_en)
     ,.flush_o(flush)
     ,.fill_v_o(fill_v)
     ,.fill_addr_o(fill_addr)
     ,.fill_data_o(fill_data)
     );

  // IF0
  fe_pc_gen pc_gen
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.redirect_i(redirect)
     ,.fetch_en_i(fetch_en)
     ,.next_pc_o(next_pc)
     );

  assign if1_n = '{pc: next_pc};

  fe_stage_reg #(.payload_t(fe_pkg::fe_if1_s)) if1_reg
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.v_i(fetch_en)
     ,.data_i(if1_n)
     ,.flush_i(flush[0])
     ,.v_o(if1_v)
     ,.data_o(if1_q)
     );

  // IF1 reads memory, data lands with the item in IF2
  fe_imem imem
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.rd_pc_i(if1_q.pc)
     ,.fill_v_i(fill_v)
     ,.fill_addr_i(fill_addr)
     ,.fill_data_i(fill_data)
     ,.misaligned_o(imem_misaligned)
     ,.out_of_range_o(imem_out_of_range)
     ,.instr_o(imem_instr)
     );

  assign if2_n = '{pc: if1_q.pc, misaligned: imem_misaligned, out_of_range: imem_out_of_range};

  fe_stage_reg #(.payload_t(fe_pkg::fe_if2_s)) if2_reg
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.v_i(if1_v)
     ,.data_i(if2_n)
     ,.flush_i(flush[1])
     ,.v_o(if2_v)
     ,.data_o(if2_q)
     );

  fe_msg_former msg_former
    (.if2_v_i(if2_v)
     ,.if2_i(if2_q)
     ,.instr_i(imem_instr)
     ,.fe_queue_ready_i(fe_queue_ready_i)
     ,.fe_queue_o(fe_queue_o)
     ,.fe_queue_v_o(fe_queue_v_o)
     ,.fetch_done_o(fetch_done)
     ,.exception_done_o(exception_done)
     ,.fetch_fail_o(fetch_fail)
     );

endmodule

//--- tb_fe_top.sv
`timescale 1ns/1ps
`include "fe_consts.svh"

module tb_fe_top;

  // Six tests of a few hundred cycles at most with back-pressure the longest
  localparam int max_cycles_lp = 4000;

  logic clk_i;
  logic reset_i;
  fe_pkg::fe_cmd_s fe_cmd_i;
  logic fe_cmd_v_i;
  logic fe_cmd_yumi_o;
  fe_pkg::fe_queue_s fe_queue_o;
  logic fe_queue_v_o;
  logic fe_queue_ready_i;

  logic ready_level;
  logic ready_lfsr;
  logic [31:0] lfsr_r;
  logic [`FE_INSTR_WIDTH-1:0] model_mem [`FE_IMEM_WORDS];
  fe_pkg::fe_queue_s msg_q[$];
  int cycle_cnt = 0;
  int check_cnt = 0;
  int err_cnt = 0;
  int test_cnt = 0;

  fe_top DUT
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.fe_cmd_i(fe_cmd_i)
     ,.fe_cmd_v_i(fe_cmd_v_i)
     ,.fe_cmd_yumi_o(fe_cmd_yumi_o)
     ,.fe_queue_o(fe_queue_o)
     ,.fe_queue_v_o(fe_queue_v_o)
     ,.fe_queue_ready_i(fe_queue_ready_i)
     );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
    lfsr_r = {lfsr_r[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++)
      w = {w[30:0], next_rand_bit()};
    return w;
  endfunction

  // Ready for the coming cycle
  always @(posedge clk_i)
  begin
    #2;
    if (ready_lfsr)
      fe_queue_ready_i = next_rand_bit();
    else
      fe_queue_ready_i = ready_level;
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Queue monitor samples at the falling edge where outputs are settled
  always @(negedge clk_i)
  begin
    if (!reset_i && fe_queue_v_o)
    begin
      check_val("fe_queue_ready_i", fe_queue_ready_i, 1'b1);
      msg_q.push_back(fe_queue_o);
    end
  end

  task automatic set_ready(input logic use_lfsr, input logic level);
    @(negedge clk_i);
    ready_lfsr = use_lfsr;
    ready_level = level;
  endtask

  // A command is taken in the same cycle it is offered
  task automatic send_cmd(input fe_pkg::fe_cmd_opcode_e op,
                          input logic [`FE_VADDR_WIDTH-1:0] vaddr,
                          input logic [`FE_INSTR_WIDTH-1:0] instr);
    @(posedge clk_i);
    #2;
    fe_cmd_i = '{opcode: op, vaddr: vaddr, instr: instr};
    fe_cmd_v_i = 1'b1;
    @(negedge clk_i);
    check_val("fe_cmd_yumi_o", fe_cmd_yumi_o, 1'b1);
    @(posedge clk_i);
    #2;
    fe_cmd_v_i = 1'b0;
  endtask

  task automatic fill_word(input int word);
    logic [`FE_INSTR_WIDTH-1:0] data;
    data = rand_word();
    model_mem[word] = data;
    send_cmd(fe_pkg::e_op_imem_fill, `FE_VADDR_WIDTH'(word * 4), data);
  endtask

  task automatic wait_msgs(input int n);
    while (msg_q.size() < n)
      @(posedge clk_i);
  endtask

  task automatic check_fetch_seq(input int n, input logic [`FE_VADDR_WIDTH-1:0] base);
    logic [`FE_VADDR_WIDTH-1:0] pc;
    for (int i = 0; i < n; i++)
    begin
      pc = base + `FE_VADDR_WIDTH'(`FE_PC_STEP * i);
      check_val("fe_queue_o.msg_type", msg_q[i].msg_type, fe_pkg::e_fe_fetch);
      check_val("fe_queue_o.pc", msg_q[i].pc, pc);
      check_val("fe_queue_o.instr", msg_q[i].instr, model_mem[pc[7:2]]);
    end
  endtask

  task automatic check_exc(input int idx, input fe_pkg::fe_exc_code_e code,
                           input logic [`FE_VADDR_WIDTH-1:0] pc);
    check_val("fe_queue_o.msg_type", msg_q[idx].msg_type, fe_pkg::e_fe_exception);
    check_val("fe_queue_o.exc_code", msg_q[idx].exc_code, code);
    check_val("fe_queue_o.pc", msg_q[idx].pc, pc);
    check_val("fe_queue_o.instr", msg_q[idx].instr, '0);
  endtask

  task automatic report(input string name, input int err_before);
    test_cnt++;
    $display("test %0d %s finished with %0d errors", test_cnt, name, err_cnt - err_before);
  endtask

  task automatic test_idle_after_reset();
    int e0;
    e0 = err_cnt;
    repeat (10)
    begin
      @(negedge clk_i);
      check_val("fe_queue_v_o", fe_queue_v_o, 1'b0);
      check_val("fe_cmd_yumi_o", fe_cmd_yumi_o, 1'b0);
    end
    report("idle after reset", e0);
  endtask

  // Fill words 0 to 15, fetch from 0 and check the first 12 messages
  task automatic test_fetch_run(input logic use_lfsr, input string name);
    int e0;
    e0 = err_cnt;
    set_ready(1'b0, 1'b1);
    for (int w = 0; w < 16; w++)
      fill_word(w);
    msg_q.delete();
    set_ready(use_lfsr, 1'b1);
    send_cmd(fe_pkg::e_op_pc_redirect, '0, '0);
    wait_msgs(12);
    send_cmd(fe_pkg::e_op_wait, '0, '0);
    set_ready(1'b0, 1'b1);
    repeat (5) @(posedge clk_i);
    check_fetch_seq(12, '0);
    report(name, e0);
  endtask

  task automatic test_misaligned();
    int e0;
    e0 = err_cnt;
    msg_q.delete();
    send_cmd(fe_pkg::e_op_pc_redirect, 16'h0102, '0);
    wait_msgs(1);
    repeat (10) @(negedge clk_i);
    check_val("message count", msg_q.size(), 1);
    check_exc(0, fe_pkg::e_instr_misaligned, 16'h0102);
    report("misaligned redirect", e0);
  endtask

  task automatic test_access_fault();
    int e0;
    e0 = err_cnt;
    fill_word(62);
    fill_word(63);
    msg_q.delete();
    send_cmd(fe_pkg::e_op_pc_redirect, 16'd248, '0);
    wait_msgs(3);
    repeat (10) @(negedge clk_i);
    check_val("message count", msg_q.size(), 3);
    check_fetch_seq(2, 16'd248);
    check_exc(2, fe_pkg::e_instr_access_fault, 16'd256);
    report("end of memory", e0);
  endtask

  task automatic test_fill_and_wait();
    int e0;
    int n_stop;
    e0 = err_cnt;
    for (int w = 16; w < 32; w++)
      fill_word(w);
    msg_q.delete();
    send_cmd(fe_pkg::e_op_pc_redirect, '0, '0);
    wait_msgs(2);
    // Word 20 is still well ahead of the fetch PC here
    fill_word(20);
    wait_msgs(24);
    send_cmd(fe_pkg::e_op_wait, '0, '0);
    repeat (3) @(negedge clk_i);
    n_stop = msg_q.size();
    repeat (10) @(negedge clk_i);
    check_val("message count after wait", msg_q.size(), n_stop);
    check_fetch_seq(n_stop, '0);
    report("fill and wait while running", e0);
  endtask

  initial
  begin
    reset_i = 1'b1;
    fe_cmd_i = '0;
    fe_cmd_v_i = 1'b0;
    fe_queue_ready_i = 1'b1;
    ready_level = 1'b1;
    ready_lfsr = 1'b0;
    lfsr_r = 32'h8318_49e0;
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    test_idle_after_reset();
    test_fetch_run(1'b0, "sequential fetch");
    test_fetch_run(1'b1, "back-pressure");
    test_misaligned();
    test_access_fault();
    test_fill_and_wait();

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    wait (cycle_cnt >= max_cycles_lp);
    $display("Timeout after %0d cycles, a test is stuck waiting on the DUT", max_cycles_lp);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
